// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;

    // major opcodes, rv64i only
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_W     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;

    // arithmetic group, shared by reg and imm forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    // one instruction word, seen as r-type or i-type
    typedef union packed {
        struct packed {
            logic [6:0] func7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12; // bit 10 marks srai
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } rv_inst_u;

endpackage

`default_nettype wire

// ==== logic/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

    // log2 of the access width in bytes
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_e;

endpackage

`default_nettype wire

// ==== logic/ex_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_decoder
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  wire rv_inst_u  inst_i,
    output alu_op_e        alu_op_o,
    output logic           is_word_o,
    output logic           is_branch_o,
    output br_cond_e       br_cond_o,
    output logic           is_jump_o,
    output logic           is_load_o,
    output logic           is_store_o,
    output mem_size_e      mem_size_o,
    output logic           rd_wen_o,
    output logic [4:0]     rd_addr_o
);

    logic    is_reg_form; // op / op-32
    logic    word_f3_ok;
    alu_op_e arith_op;

    assign is_reg_form = (inst_i.r.opcode == OPC_OP) || (inst_i.r.opcode == OPC_OP_W);
    assign word_f3_ok  = (inst_i.r.func3 == F3_ADD_SUB) || (inst_i.r.func3 == F3_SLL) ||
                         (inst_i.r.func3 == F3_SR);
    assign rd_addr_o   = inst_i.r.rd;

    // arithmetic func3 shared by all four arithmetic opcodes
    always_comb begin
        case (inst_i.r.func3)
            F3_ADD_SUB: arith_op = (is_reg_form && inst_i.r.func7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SR:      arith_op = inst_i.i.imm12[10] ? ALU_SRA : ALU_SRL; // bit 30 in both views
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_ADD;
        is_word_o   = 1'b0;
        is_branch_o = 1'b0;
        br_cond_o   = BR_EQ;
        is_jump_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        mem_size_o  = SIZE_B;
        rd_wen_o    = 1'b0;

        case (inst_i.r.opcode)
            OPC_OP_IMM, OPC_OP: begin
                alu_op_o = arith_op;
                rd_wen_o = 1'b1;
            end
            OPC_OP_IMM_W, OPC_OP_W: begin
                if (word_f3_ok) begin
                    alu_op_o  = arith_op;
                    is_word_o = 1'b1;
                    rd_wen_o  = 1'b1;
                end
            end
            OPC_BRANCH: begin
                is_branch_o = 1'b1;
                case (inst_i.r.func3)
                    F3_BEQ:  br_cond_o = BR_EQ;
                    F3_BNE:  br_cond_o = BR_NE;
                    F3_BLT:  br_cond_o = BR_LT;
                    F3_BGE:  br_cond_o = BR_GE;
                    F3_BLTU: br_cond_o = BR_LTU;
                    F3_BGEU: br_cond_o = BR_GEU;
                    default: is_branch_o = 1'b0; // 010 / 011 reserved
                endcase
            end
            OPC_LOAD: begin
                is_load_o = 1'b1;
                case (inst_i.r.func3)
                    F3_LB, F3_LBU: mem_size_o = SIZE_B;
                    F3_LH, F3_LHU: mem_size_o = SIZE_H;
                    F3_LW, F3_LWU: mem_size_o = SIZE_W;
                    F3_LD:         mem_size_o = SIZE_D;
                    default:       is_load_o  = 1'b0;
                endcase
                rd_wen_o = is_load_o;
            end
            OPC_STORE: begin
                is_store_o = 1'b1;
                case (inst_i.r.func3)
                    F3_SB:   mem_size_o = SIZE_B;
                    F3_SH:   mem_size_o = SIZE_H;
                    F3_SW:   mem_size_o = SIZE_W;
                    F3_SD:   mem_size_o = SIZE_D;
                    default: is_store_o = 1'b0;
                endcase
            end
            OPC_JAL, OPC_JALR: begin
                is_jump_o = 1'b1; // link value is op1 + op2
                rd_wen_o  = 1'b1;
            end
            OPC_LUI: begin
                alu_op_o = ALU_PASS_B;
                rd_wen_o = 1'b1;
            end
            OPC_AUIPC: begin
                rd_wen_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/ex_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_alu
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    input  wire alu_op_e         alu_op_i,
    input  wire logic            is_word_i,
    output logic [XLEN-1:0]      result_o
);

    logic [5:0]      shamt;
    logic [XLEN-1:0] src_lgc; // right shift source, zero filled
    logic [XLEN-1:0] src_ari; // right shift source, sign filled
    logic [XLEN-1:0] full;

    // word shifts only look at 5 bits of the amount
    assign shamt   = is_word_i ? {1'b0, op2_i[4:0]} : op2_i[5:0];
    assign src_lgc = is_word_i ? {{(XLEN-WLEN){1'b0}}, op1_i[WLEN-1:0]} : op1_i;
    assign src_ari = is_word_i ? {{(XLEN-WLEN){op1_i[WLEN-1]}}, op1_i[WLEN-1:0]} : op1_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    full = op1_i + op2_i;
            ALU_SUB:    full = op1_i - op2_i;
            ALU_SLL:    full = op1_i << shamt;
            ALU_SLT:    full = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:   full = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_XOR:    full = op1_i ^ op2_i;
            ALU_SRL:    full = src_lgc >> shamt;
            ALU_SRA:    full = $signed(src_ari) >>> shamt;
            ALU_OR:     full = op1_i | op2_i;
            ALU_AND:    full = op1_i & op2_i;
            ALU_PASS_B: full = op2_i;
            default:    full = '0;
        endcase
    end

    // w forms keep the low word and sign extend bit 31
    assign result_o = is_word_i ? {{(XLEN-WLEN){full[WLEN-1]}}, full[WLEN-1:0]} : full;

endmodule

`default_nettype wire

// ==== logic/ex_branch_cmp.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_branch_cmp
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    input  wire logic            is_branch_i,
    input  wire br_cond_e        br_cond_i,
    input  wire logic            is_jump_i,
    output logic                 jump_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    assign eq   = (op1_i == op2_i);
    assign lt_s = ($signed(op1_i) < $signed(op2_i));
    assign lt_u = (op1_i < op2_i);

    always_comb begin
        case (br_cond_i)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt_s;
            BR_GE:   cond = !lt_s;
            BR_LTU:  cond = lt_u;
            BR_GEU:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign jump_en_o = is_jump_i | (is_branch_i & cond); // jal/jalr always taken

endmodule

`default_nettype wire

// ==== logic/ex_mem_req.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_mem_req
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  wire logic [XLEN-1:0] base_addr_i,
    input  wire logic [XLEN-1:0] offset_addr_i,
    input  wire logic [XLEN-1:0] op2_i,
    input  wire mem_size_e       mem_size_i,
    output logic [XLEN-1:0]      eff_addr_o,
    output logic [XLEN-1:0]      store_data_o,
    output logic [XLEN/8-1:0]    store_mask_o
);

    assign eff_addr_o = base_addr_i + offset_addr_i; // also the jump target

    always_comb begin
        case (mem_size_i)
            SIZE_B:  store_mask_o = 8'h01;
            SIZE_H:  store_mask_o = 8'h03;
            SIZE_W:  store_mask_o = 8'h0f;
            SIZE_D:  store_mask_o = 8'hff;
            default: store_mask_o = 8'h00;
        endcase
    end

    // bytes outside the mask read zero
    always_comb begin
        for (int b = 0; b < XLEN/8; b++) begin
            store_data_o[8*b +: 8] = store_mask_o[b] ? op2_i[8*b +: 8] : 8'h00;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_result_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_result_reg
    import rv_isa_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic [XLEN-1:0]   pc_i,
    input  wire rv_inst_u          inst_i,
    input  wire logic [XLEN-1:0]   alu_result_i,
    input  wire logic [XLEN-1:0]   eff_addr_i,
    input  wire logic [XLEN-1:0]   store_data_i,
    input  wire logic [XLEN/8-1:0] store_mask_i,
    input  wire logic              jump_en_i,
    input  wire logic              is_branch_i,
    input  wire logic              is_jump_i,
    input  wire logic              is_load_i,
    input  wire logic              is_store_i,
    input  wire logic              rd_wen_i,
    input  wire logic [4:0]        rd_addr_i,
    output rv_inst_u               inst_o,
    output logic [XLEN-1:0]        pc_o,
    output logic [XLEN-1:0]        jump_addr_o,
    output logic                   jump_en_o,
    output logic                   mem_ren_o,
    output logic [XLEN-1:0]        mem_raddr_o,
    output logic                   mem_wen_o,
    output logic [XLEN-1:0]        mem_waddr_o,
    output logic [XLEN-1:0]        mem_wdata_o,
    output logic [XLEN/8-1:0]      mem_wmask_o,
    output logic [XLEN-1:0]        rd_wdata_o,
    output logic [4:0]             rd_waddr_o,
    output logic                   reg_wen_o,
    output logic                   is_load_o,
    output logic                   is_save_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_o      <= '0;
            pc_o        <= '0;
            jump_addr_o <= '0;
            jump_en_o   <= 1'b0;
            mem_ren_o   <= 1'b0;
            mem_raddr_o <= '0;
            mem_wen_o   <= 1'b0;
            mem_waddr_o <= '0;
            mem_wdata_o <= '0;
            mem_wmask_o <= '0;
            rd_wdata_o  <= '0;
            rd_waddr_o  <= '0;
            reg_wen_o   <= 1'b0;
            is_load_o   <= 1'b0;
            is_save_o   <= 1'b0;
        end else begin
            inst_o      <= inst_i;
            pc_o        <= pc_i;
            jump_addr_o <= (is_branch_i || is_jump_i) ? eff_addr_i : '0;
            jump_en_o   <= jump_en_i;
            mem_ren_o   <= is_load_i;
            mem_raddr_o <= is_load_i ? eff_addr_i : '0;
            mem_wen_o   <= is_store_i;
            mem_waddr_o <= is_store_i ? eff_addr_i : '0;
            mem_wdata_o <= is_store_i ? store_data_i : '0;
            mem_wmask_o <= is_store_i ? store_mask_i : '0;
            // load data arrives in mem, nothing to write back yet
            rd_wdata_o  <= (rd_wen_i && !is_load_i) ? alu_result_i : '0;
            rd_waddr_o  <= rd_wen_i ? rd_addr_i : '0;
            reg_wen_o   <= rd_wen_i;
            is_load_o   <= is_load_i;
            is_save_o   <= is_store_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_stage
    import rv_isa_pkg::*;
    import ex_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire rv_inst_u        inst_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    input  wire logic [XLEN-1:0] base_addr_i,
    input  wire logic [XLEN-1:0] offset_addr_i,
    output rv_inst_u             inst_o,
    output logic [XLEN-1:0]      pc_o,
    output logic [XLEN-1:0]      jump_addr_o,
    output logic                 jump_en_o,
    output logic                 mem_ren_o,
    output logic [XLEN-1:0]      mem_raddr_o,
    output logic                 mem_wen_o,
    output logic [XLEN-1:0]      mem_waddr_o,
    output logic [XLEN-1:0]      mem_wdata_o,
    output logic [XLEN/8-1:0]    mem_wmask_o,
    output logic [XLEN-1:0]      rd_wdata_o,
    output logic [4:0]           rd_waddr_o,
    output logic                 reg_wen_o,
    output logic                 is_load_o,
    output logic                 is_save_o
);

    alu_op_e            alu_op;
    logic               is_word;
    logic               is_branch;
    br_cond_e           br_cond;
    logic               is_jump;
    logic               is_load;
    logic               is_store;
    mem_size_e          mem_size;
    logic               rd_wen;
    logic [4:0]         rd_addr;
    logic [XLEN-1:0]    alu_result;
    logic               jump_en;
    logic [XLEN-1:0]    eff_addr;
    logic [XLEN-1:0]    store_data;
    logic [XLEN/8-1:0]  store_mask;

    ex_decoder u_decoder (
        .inst_i      (inst_i),
        .alu_op_o    (alu_op),
        .is_word_o   (is_word),
        .is_branch_o (is_branch),
        .br_cond_o   (br_cond),
        .is_jump_o   (is_jump),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .mem_size_o  (mem_size),
        .rd_wen_o    (rd_wen),
        .rd_addr_o   (rd_addr)
    );

    ex_alu u_alu (
        .op1_i     (op1_i),
        .op2_i     (op2_i),
        .alu_op_i  (alu_op),
        .is_word_i (is_word),
        .result_o  (alu_result)
    );

    ex_branch_cmp u_branch_cmp (
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .is_branch_i (is_branch),
        .br_cond_i   (br_cond),
        .is_jump_i   (is_jump),
        .jump_en_o   (jump_en)
    );

    ex_mem_req u_mem_req (
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .op2_i         (op2_i),
        .mem_size_i    (mem_size),
        .eff_addr_o    (eff_addr),
        .store_data_o  (store_data),
        .store_mask_o  (store_mask)
    );

    // ex/mem boundary
    ex_result_reg u_result_reg (
        .clk          (clk),
        .reset_i      (reset_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .alu_result_i (alu_result),
        .eff_addr_i   (eff_addr),
        .store_data_i (store_data),
        .store_mask_i (store_mask),
        .jump_en_i    (jump_en),
        .is_branch_i  (is_branch),
        .is_jump_i    (is_jump),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .rd_wen_i     (rd_wen),
        .rd_addr_i    (rd_addr),
        .inst_o       (inst_o),
        .pc_o         (pc_o),
        .jump_addr_o  (jump_addr_o),
        .jump_en_o    (jump_en_o),
        .mem_ren_o    (mem_ren_o),
        .mem_raddr_o  (mem_raddr_o),
        .mem_wen_o    (mem_wen_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_wmask_o  (mem_wmask_o),
        .rd_wdata_o   (rd_wdata_o),
        .rd_waddr_o   (rd_waddr_o),
        .reg_wen_o    (reg_wen_o),
        .is_load_o    (is_load_o),
        .is_save_o    (is_save_o)
    );

endmodule

`default_nettype wire

// ==== verif/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected value of every stage output
typedef struct packed {
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] jump_addr;
    logic        jump_en;
    logic        mem_ren;
    logic [63:0] mem_raddr;
    logic        mem_wen;
    logic [63:0] mem_waddr;
    logic [63:0] mem_wdata;
    logic [7:0]  mem_wmask;
    logic [63:0] rd_wdata;
    logic [4:0]  rd_waddr;
    logic        reg_wen;
    logic        is_load;
    logic        is_save;
} ex_out_t;

// integer ops by func3, word forms work on the low 32 bits
function automatic logic [63:0] arith_ref(input logic [2:0] f3, input logic sub,
                                          input logic sra, input logic word,
                                          input logic [63:0] a, input logic [63:0] b);
    logic [5:0]  sh;
    logic [63:0] r;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    case (f3)
        F3_ADD_SUB: r = sub ? a - b : a + b;
        F3_SLL:     r = a << sh;
        F3_SLT:     r = {63'd0, $signed(a) < $signed(b)};
        F3_SLTU:    r = {63'd0, a < b};
        F3_XOR:     r = a ^ b;
        F3_SR: begin
            if (word && sra)
                r = $signed({{32{a[31]}}, a[31:0]}) >>> sh;
            else if (word)
                r = {32'd0, a[31:0]} >> sh;
            else if (sra)
                r = $signed(a) >>> sh;
            else
                r = a >> sh;
        end
        F3_OR:      r = a | b;
        default:    r = a & b;
    endcase
    if (word)
        r = {{32{r[31]}}, r[31:0]}; // sign extend bit 31
    return r;
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [63:0] a,
                                    input logic [63:0] b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        default: return a >= b; // bgeu
    endcase
endfunction

function automatic ex_out_t ex_ref(input logic [31:0] inst, input logic [63:0] pc,
                                   input logic [63:0] op1, input logic [63:0] op2,
                                   input logic [63:0] base, input logic [63:0] offset);
    ex_out_t     o;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [63:0] ea;
    o   = '0;
    opc = inst[6:0];
    f3  = inst[14:12];
    ea  = base + offset;
    o.inst = inst;
    o.pc   = pc;
    case (opc)
        OPC_OP, OPC_OP_IMM: begin
            o.reg_wen  = 1'b1;
            o.rd_wdata = arith_ref(f3, inst[30] && opc == OPC_OP, inst[30], 1'b0, op1, op2);
        end
        OPC_OP_W, OPC_OP_IMM_W: begin
            if (f3 == F3_ADD_SUB || f3 == F3_SLL || f3 == F3_SR) begin
                o.reg_wen  = 1'b1;
                o.rd_wdata = arith_ref(f3, inst[30] && opc == OPC_OP_W, inst[30], 1'b1,
                                       op1, op2);
            end
        end
        OPC_BRANCH: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin // two reserved codes
                o.jump_addr = ea;
                o.jump_en   = branch_ref(f3, op1, op2);
            end
        end
        OPC_LOAD: begin
            if (f3 != 3'b111) begin
                o.mem_ren   = 1'b1;
                o.mem_raddr = ea;
                o.is_load   = 1'b1;
                o.reg_wen   = 1'b1; // data comes back later
            end
        end
        OPC_STORE: begin
            if (!f3[2]) begin
                o.mem_wen   = 1'b1;
                o.mem_waddr = ea;
                o.is_save   = 1'b1;
                case (f3[1:0])
                    2'd0: o.mem_wdata = {56'd0, op2[7:0]};
                    2'd1: o.mem_wdata = {48'd0, op2[15:0]};
                    2'd2: o.mem_wdata = {32'd0, op2[31:0]};
                    default: o.mem_wdata = op2;
                endcase
                o.mem_wmask = 8'hff >> (8 - (1 << f3[1:0]));
            end
        end
        OPC_JAL, OPC_JALR: begin
            o.reg_wen   = 1'b1;
            o.rd_wdata  = op1 + op2;
            o.jump_en   = 1'b1;
            o.jump_addr = ea;
        end
        OPC_LUI: begin
            o.reg_wen  = 1'b1;
            o.rd_wdata = op2;
        end
        OPC_AUIPC: begin
            o.reg_wen  = 1'b1;
            o.rd_wdata = op1 + op2;
        end
        default: begin
        end
    endcase
    if (o.reg_wen)
        o.rd_waddr = inst[11:7];
    return o;
endfunction

`endif

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage
    import rv_isa_pkg::*;
;

`include "ex_ref_model.svh"

    logic        clk;
    logic        reset_i;
    logic [31:0] inst_i;
    logic [63:0] pc_i;
    logic [63:0] op1_i;
    logic [63:0] op2_i;
    logic [63:0] base_addr_i;
    logic [63:0] offset_addr_i;
    logic [31:0] inst_o;
    logic [63:0] pc_o;
    logic [63:0] jump_addr_o;
    logic        jump_en_o;
    logic        mem_ren_o;
    logic [63:0] mem_raddr_o;
    logic        mem_wen_o;
    logic [63:0] mem_waddr_o;
    logic [63:0] mem_wdata_o;
    logic [7:0]  mem_wmask_o;
    logic [63:0] rd_wdata_o;
    logic [4:0]  rd_waddr_o;
    logic        reg_wen_o;
    logic        is_load_o;
    logic        is_save_o;

    ex_out_t     exp_q[$];  // one entry per applied instruction
    string       name_q[$];
    int          applied;
    int          checked;
    logic [31:0] lcg_state;

    ex_stage u_ex_stage (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .jump_addr_o   (jump_addr_o),
        .jump_en_o     (jump_en_o),
        .mem_ren_o     (mem_ren_o),
        .mem_raddr_o   (mem_raddr_o),
        .mem_wen_o     (mem_wen_o),
        .mem_waddr_o   (mem_waddr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wmask_o   (mem_wmask_o),
        .rd_wdata_o    (rd_wdata_o),
        .rd_waddr_o    (rd_waddr_o),
        .reg_wen_o     (reg_wen_o),
        .is_load_o     (is_load_o),
        .is_save_o     (is_save_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    // random register fields only reach rd_waddr_o
    function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        logic [31:0] r;
        r = next_rand();
        return {f7, r[4:0], r[9:5], f3, r[14:10], opc};
    endfunction

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [6:0] opc);
        logic [31:0] r;
        r = next_rand();
        return {imm, r[9:5], f3, r[14:10], opc};
    endfunction

    task automatic check_val(input string test, input string field,
                             input logic [63:0] exp_v, input logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test, field, exp_v, act_v);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_outputs(input string test, input ex_out_t e);
        check_val(test, "inst_o", e.inst, inst_o);
        check_val(test, "pc_o", e.pc, pc_o);
        check_val(test, "jump_addr_o", e.jump_addr, jump_addr_o);
        check_val(test, "jump_en_o", e.jump_en, jump_en_o);
        check_val(test, "mem_ren_o", e.mem_ren, mem_ren_o);
        check_val(test, "mem_raddr_o", e.mem_raddr, mem_raddr_o);
        check_val(test, "mem_wen_o", e.mem_wen, mem_wen_o);
        check_val(test, "mem_waddr_o", e.mem_waddr, mem_waddr_o);
        check_val(test, "mem_wdata_o", e.mem_wdata, mem_wdata_o);
        check_val(test, "mem_wmask_o", e.mem_wmask, mem_wmask_o);
        check_val(test, "rd_wdata_o", e.rd_wdata, rd_wdata_o);
        check_val(test, "rd_waddr_o", e.rd_waddr, rd_waddr_o);
        check_val(test, "reg_wen_o", e.reg_wen, reg_wen_o);
        check_val(test, "is_load_o", e.is_load, is_load_o);
        check_val(test, "is_save_o", e.is_save, is_save_o);
    endtask

    task automatic apply(input string test, input logic [31:0] inst, input logic [63:0] pc,
                         input logic [63:0] op1, input logic [63:0] op2,
                         input logic [63:0] base, input logic [63:0] offset);
        @(posedge clk);
        #1;
        inst_i        = inst;
        pc_i          = pc;
        op1_i         = op1;
        op2_i         = op2;
        base_addr_i   = base;
        offset_addr_i = offset;
        exp_q.push_back(ex_ref(inst, pc, op1, op2, base, offset));
        name_q.push_back(test);
        applied++;
    endtask

    // pc, base and offset random
    task automatic apply_ops(input string test, input logic [31:0] inst,
                             input logic [63:0] op1, input logic [63:0] op2);
        apply(test, inst, rand64(), op1, op2, rand64(), rand64());
    endtask

    // outputs settle after the edge that captured the popped entry
    initial begin : compare_proc
        ex_out_t exp_o;
        string   test;
        forever begin
            @(posedge clk);
            if (exp_q.size() > 0) begin
                exp_o = exp_q.pop_front();
                test  = name_q.pop_front();
                #2;
                check_outputs(test, exp_o);
                checked++;
            end
        end
    end

    initial begin : main_seq
        int          wait_cycles;
        logic [31:0] r;
        logic [63:0] a;
        logic [2:0]  br_codes [6];
        logic [63:0] lhs [3];
        logic [63:0] rhs [3];

        inst_i        = '0;
        pc_i          = '0;
        op1_i         = '0;
        op2_i         = '0;
        base_addr_i   = '0;
        offset_addr_i = '0;
        applied       = 0;
        checked       = 0;
        lcg_state     = 32'd38133;
        br_codes = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        lhs      = '{64'h1234, 64'hffff_ffff_ffff_fffb, 64'hffff_ffff_ffff_fff0};
        rhs      = '{64'h1234, 64'd3, 64'd1}; // equal, signed neg, unsigned large

        // live instructions go in so that only reset keeps the outputs clear
        wait_cycles = 0;
        do begin
            @(posedge clk);
            #1;
            r = next_rand();
            case (wait_cycles % 3)
                0:       inst_i = r_inst(7'h00, F3_SD, OPC_STORE);
                1:       inst_i = i_inst(r[11:0], F3_LD, OPC_LOAD);
                default: inst_i = {r[31:7], OPC_JAL};
            endcase
            pc_i          = rand64();
            op1_i         = rand64();
            op2_i         = rand64();
            base_addr_i   = rand64();
            offset_addr_i = rand64();
            #1;
            check_outputs("reset", '0);
            wait_cycles++;
            if (wait_cycles > 20) begin
                $display("reset was not released within 20 cycles");
                $display("Test failures found");
                $fatal(1);
            end
        end while (reset_i);
        @(posedge clk);
        #2;
        check_outputs("post_reset", ex_ref(inst_i, pc_i, op1_i, op2_i, base_addr_i,
                                           offset_addr_i));

        for (int n = 0; n < 200; n++) begin
            r = next_rand();
            apply_ops("arith_rand", r_inst({1'b0, r[1], 5'd0}, r[4:2], r[0] ? OPC_OP : OPC_OP_IMM),
                      rand64(), rand64());
        end

        // word forms around the 32 bit boundary
        apply_ops("addw_ovf", r_inst(7'h00, F3_ADD_SUB, OPC_OP_W), 64'h7fff_ffff, 64'd1);
        apply_ops("subw_ovf", r_inst(7'h20, F3_ADD_SUB, OPC_OP_W), 64'h8000_0000, 64'd1);
        apply_ops("sllw_sh33", r_inst(7'h00, F3_SLL, OPC_OP_W), 64'h4000_0001, 64'd33);
        apply_ops("srlw_sh36", r_inst(7'h00, F3_SR, OPC_OP_W), 64'hffff_ffff_8000_0000, 64'd36);
        apply_ops("sraw_sh63", r_inst(7'h20, F3_SR, OPC_OP_W), 64'h8000_0000, 64'd63);
        apply_ops("addiw_ovf", i_inst(12'h001, F3_ADD_SUB, OPC_OP_IMM_W), 64'h7fff_ffff, 64'd1);
        apply_ops("sraiw", i_inst(12'h41f, F3_SR, OPC_OP_IMM_W), 64'h8000_0000, 64'h41f);
        apply_ops("sltw_invalid", r_inst(7'h00, F3_SLT, OPC_OP_W), rand64(), rand64());
        for (int n = 0; n < 100; n++) begin
            r = next_rand();
            a = {next_rand(), r[16] ? 32'h8000_0000 : 32'h7fff_ff00};
            a[7:0] = r[7:0];
            apply_ops("word_rand",
                      r_inst({1'b0, r[17], 5'd0}, r[18] ? F3_SR : {2'b00, r[19]},
                             r[20] ? OPC_OP_W : OPC_OP_IMM_W),
                      a, {next_rand(), 24'd0, r[15:8]});
        end

        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                apply_ops("branch", r_inst(7'h00, br_codes[c], OPC_BRANCH), lhs[p], rhs[p]);
                apply_ops("branch_swap", r_inst(7'h00, br_codes[c], OPC_BRANCH), rhs[p], lhs[p]);
            end
        end
        apply_ops("branch_reserved", r_inst(7'h00, 3'b010, OPC_BRANCH), 64'd7, 64'd7);

        for (int f = 0; f < 8; f++) begin
            r = next_rand();
            apply_ops("load", i_inst(r[11:0], 3'(f), OPC_LOAD), rand64(), rand64());
        end
        for (int f = 0; f < 5; f++) begin
            apply_ops("store", r_inst(7'h00, 3'(f), OPC_STORE), rand64(), rand64());
            apply_ops("store", r_inst(7'h3f, 3'(f), OPC_STORE), rand64(), rand64());
        end

        r = next_rand();
        a = rand64();
        apply("jal", {r[31:12], r[11:7], OPC_JAL}, a, a, 64'd4, a, rand64());
        apply("jalr", i_inst(r[11:0], 3'b000, OPC_JALR), a, a, 64'd4, rand64(), rand64());
        apply_ops("lui", {r[31:12], r[11:7], OPC_LUI}, rand64(),
                  {{32{r[31]}}, r[31:12], 12'h000});
        apply("auipc", {r[31:12], r[11:7], OPC_AUIPC}, a, a, {{32{r[31]}}, r[31:12], 12'h000},
              rand64(), rand64());
        apply_ops("unknown_op", {r[31:7], 7'h7f}, rand64(), rand64());
        apply_ops("unknown_op", {r[31:7], 7'h0b}, rand64(), rand64());

        wait_cycles = 0;
        while (checked < applied) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 10) begin
                $display("compare process did not finish within 10 cycles");
                $display("Test failures found");
                $fatal(1);
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verif
logic/rv_isa_pkg.sv
logic/ex_pkg.sv
logic/ex_decoder.sv
logic/ex_alu.sv
logic/ex_branch_cmp.sv
logic/ex_mem_req.sv
logic/ex_result_reg.sv
logic/ex_stage.sv
verif/tb_ex_stage.sv
